//--- list.f
rtl/cdc_fifo_pkg.sv
rtl/fifo_dp_ram.sv
rtl/gray_ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
verification/async_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module async_fifo_tb \
  -f list.f \
  -o Vasync_fifo_tb

sim_out="$(./obj_dir/Vasync_fifo_tb 2>&1 || true)"
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q '^TEST OK$'; then
  exit 0
fi
exit 1

//--- verification/async_fifo_tb.sv
`default_nettype none

module async_fifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cdc_fifo_pkg::*;

  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_AFULL  = FIFO_DEPTH - 2;
  localparam int FIFO_AEMPTY = 2;

  localparam int SEED         = 32'h7e5fdb47;
  localparam int PHASE_CYCLES = 400;
  localparam int GAP_CYCLES   = 12;
  localparam int TOTAL_CYCLES = 3 * PHASE_CYCLES + 3 * GAP_CYCLES + 2 * (FIFO_DEPTH + 4) + 10;
  // Four times the slowest clock period per cycle plus a fixed margin.
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 13 * 4 + 2000;

  logic                  wr_clk   = 1'b0;
  logic                  rd_clk   = 1'b0;
  logic                  wr_rst_n = 1'b0;
  logic                  rd_rst_n = 1'b0;
  logic                  wr_en    = 1'b0;
  logic                  rd_en    = 1'b0;
  logic [DATA_WIDTH-1:0] wr_data  = '0;
  logic [DATA_WIDTH-1:0] rd_data;
  wr_flags_t             wr_flags;
  rd_flags_t             rd_flags;

  // The phase sequence sets the strobe densities in percent.
  int wr_pct = 0;
  int rd_pct = 0;

  // The two clocks never share an edge, so one stream serves both domains.
  int seed = SEED;

  // Model state. The counters change by non-blocking assignment so both
  // domains see the values from before a shared edge.
  logic [DATA_WIDTH-1:0] model_q[$];
  logic [DATA_WIDTH-1:0] exp_rd_data = '0;
  int                    wr_count = 0;
  int                    rd_count = 0;
  int                    wr_level;
  int                    rd_level;

  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_flags (rd_flags)
  );

  initial forever #5 rd_clk = ~rd_clk;

  initial forever #6.5 wr_clk = ~wr_clk;

  // ##############################
  // Helpers
  // ##############################

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t signal %s actual 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic run_phase(input int wr_p, input int rd_p, input int cycles);
    wr_pct <= wr_p;
    rd_pct <= rd_p;
    repeat (cycles) @(posedge rd_clk);
  endtask

  task automatic fill_to_full();
    int n;
    n = 0;
    wr_pct <= 100;
    rd_pct <= 0;
    @(posedge wr_clk);
    while (!wr_flags.full && n < FIFO_DEPTH + 4) begin
      @(posedge wr_clk);
      n++;
    end
    if (!wr_flags.full) begin
      $display("full did not rise within %0d write cycles", FIFO_DEPTH + 4);
      abort_run();
    end
  endtask

  task automatic drain_to_empty();
    int n;
    n = 0;
    wr_pct <= 0;
    rd_pct <= 100;
    @(posedge rd_clk);
    while (!rd_flags.empty && n < FIFO_DEPTH + 4) begin
      @(posedge rd_clk);
      n++;
    end
    if (!rd_flags.empty) begin
      $display("empty did not rise within %0d read cycles", FIFO_DEPTH + 4);
      abort_run();
    end
  endtask

  // ##############################
  // Write domain
  // ##############################

  always @(posedge wr_clk) begin
    if (wr_rst_n) begin
      wr_level = wr_count - rd_count;
      if (!wr_flags.full && wr_level >= FIFO_DEPTH) begin
        $display("full was low at time %0t while the FIFO held %0d words", $time, wr_level);
        abort_run();
      end
      if (!wr_flags.afull && wr_level >= FIFO_AFULL) begin
        $display("afull was low at time %0t while the FIFO held %0d words", $time, wr_level);
        abort_run();
      end
      if (wr_en && !wr_flags.full) begin
        model_q.push_back(wr_data);
        wr_count <= wr_count + 1;
      end
      wr_en   <= ($unsigned($random(seed)) % 100) < wr_pct;
      wr_data <= DATA_WIDTH'($random(seed));
    end
  end

  // ##############################
  // Read domain
  // ##############################

  // rd_data must show the word of the last accepted read, or zero after reset.
  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      rd_level = wr_count - rd_count;
      check_value("rd_data", 32'(rd_data), 32'(exp_rd_data));
      if (!rd_flags.empty && rd_level < 1) begin
        $display("empty was low at time %0t while the FIFO held no word", $time);
        abort_run();
      end
      if (!rd_flags.aempty && rd_level <= FIFO_AEMPTY) begin
        $display("aempty was low at time %0t while the FIFO held %0d words", $time, rd_level);
        abort_run();
      end
      if (rd_en && !rd_flags.empty) begin
        if (model_q.size() == 0) begin
          $display("a read was accepted at time %0t with no word in the model", $time);
          abort_run();
        end
        exp_rd_data = model_q.pop_front();
        rd_count <= rd_count + 1;
      end
      rd_en <= ($unsigned($random(seed)) % 100) < rd_pct;
    end
  end

  // ##############################
  // Sequence
  // ##############################

  initial begin
    repeat (5) @(posedge rd_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;
    @(posedge rd_clk);
    check_value("wr_flags.full", 32'(wr_flags.full), 32'd0);
    check_value("wr_flags.afull", 32'(wr_flags.afull), 32'd0);
    check_value("rd_flags.empty", 32'(rd_flags.empty), 32'd1);
    check_value("rd_flags.aempty", 32'(rd_flags.aempty), 32'd1);
    check_value("rd_data", 32'(rd_data), 32'd0);

    // Heavy writing, heavy reading, then balanced traffic.
    run_phase(90, 20, PHASE_CYCLES);
    run_phase(20, 90, PHASE_CYCLES);
    run_phase(50, 50, PHASE_CYCLES);

    run_phase(0, 0, GAP_CYCLES);
    fill_to_full();
    run_phase(0, 0, GAP_CYCLES);
    drain_to_empty();
    run_phase(0, 0, GAP_CYCLES);

    if (model_q.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("the model still holds %0d words at the end of the run", model_q.size());
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    abort_run();
  end

endmodule

`default_nettype wire

//--- rtl/async_fifo.sv
`default_nettype none

module async_fifo #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2
) (
  // Write domain
  input  wire                       wr_clk,
  input  wire                       wr_rst_n,
  input  wire                       wr_en,
  input  wire  [DATA_WIDTH-1:0]     wr_data,
  output cdc_fifo_pkg::wr_flags_t   wr_flags,
  // Read domain
  input  wire                       rd_clk,
  input  wire                       rd_rst_n,
  input  wire                       rd_en,
  output logic [DATA_WIDTH-1:0]     rd_data,
  output cdc_fifo_pkg::rd_flags_t   rd_flags
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PTR_W      = ADDR_WIDTH + 1;

  logic                  we;
  logic [ADDR_WIDTH-1:0] waddr;
  logic [PTR_W-1:0]      wr_ptr_gray;
  logic [PTR_W-1:0]      rd_ptr_bin_wsync;

  logic                  re;
  logic [ADDR_WIDTH-1:0] raddr;
  logic [PTR_W-1:0]      rd_ptr_gray;
  logic [PTR_W-1:0]      wr_ptr_bin_rsync;

  // ##############################
  // Write side
  // ##############################

  fifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .rd_ptr_bin_wsync (rd_ptr_bin_wsync),
    .we               (we),
    .waddr            (waddr),
    .wr_ptr_gray      (wr_ptr_gray),
    .wr_flags         (wr_flags)
  );

  // Read pointer into the write domain.
  gray_ptr_sync #(
    .PTR_W (PTR_W)
  ) u_rd2wr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_ptr_gray),
    .bin_out   (rd_ptr_bin_wsync)
  );

  // ##############################
  // Read side
  // ##############################

  fifo_rd_ctrl #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_bin_rsync (wr_ptr_bin_rsync),
    .re               (re),
    .raddr            (raddr),
    .rd_ptr_gray      (rd_ptr_gray),
    .rd_flags         (rd_flags)
  );

  // Write pointer into the read domain.
  gray_ptr_sync #(
    .PTR_W (PTR_W)
  ) u_wr2rd_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_ptr_gray),
    .bin_out   (wr_ptr_bin_rsync)
  );

  // ##############################
  // Storage
  // ##############################

  fifo_dp_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .re       (re),
    .raddr    (raddr),
    .rdata    (rd_data)
  );

endmodule

`default_nettype wire

//--- rtl/fifo_rd_ctrl.sv
`default_nettype none

module fifo_rd_ctrl #(
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AEMPTY = 2,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH),
  localparam int PTR_W = ADDR_WIDTH + 1
) (
  input  wire                         rd_clk,
  input  wire                         rd_rst_n,
  input  wire                         rd_en,
  input  wire [PTR_W-1:0]             wr_ptr_bin_rsync,
  output logic                        re,
  output logic [ADDR_WIDTH-1:0]       raddr,
  output logic [PTR_W-1:0]            rd_ptr_gray,
  output cdc_fifo_pkg::rd_flags_t     rd_flags
);

  import cdc_fifo_pkg::*;

  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W-1:0]     rd_ptr_nxt;
  logic [PTR_W-1:0]     level_nxt;
  logic [MAX_PTR_W-1:0] gray_nxt_ext;
  logic                 rd_acc;
  rd_flags_t            flags_nxt;

  // ##############################
  // Read acceptance and pointer
  // ##############################

  assign rd_acc     = rd_en && !rd_flags.empty;
  assign rd_ptr_nxt = rd_ptr + PTR_W'(rd_acc);

  // The RAM output register loads on the accepting edge.
  assign re    = rd_acc;
  assign raddr = rd_ptr[ADDR_WIDTH-1:0];

  assign gray_nxt_ext = bin_to_gray(MAX_PTR_W'(rd_ptr_nxt));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= gray_nxt_ext[PTR_W-1:0];
    end
  end

  // ##############################
  // Empty and almost-empty
  // ##############################

  // A stale write pointer makes the level look lower than it is, so a
  // word is never read before it has been written.
  assign level_nxt = wr_ptr_bin_rsync - rd_ptr_nxt;

  assign flags_nxt.empty  = (rd_ptr_nxt == wr_ptr_bin_rsync);
  assign flags_nxt.aempty = int'(level_nxt) <= FIFO_AEMPTY;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_flags <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_flags <= flags_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fifo_wr_ctrl.sv
`default_nettype none

module fifo_wr_ctrl #(
  parameter int FIFO_DEPTH = 16,
  parameter int FIFO_AFULL = FIFO_DEPTH - 2,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH),
  localparam int PTR_W = ADDR_WIDTH + 1
) (
  input  wire                         wr_clk,
  input  wire                         wr_rst_n,
  input  wire                         wr_en,
  input  wire [PTR_W-1:0]             rd_ptr_bin_wsync,
  output logic                        we,
  output logic [ADDR_WIDTH-1:0]       waddr,
  output logic [PTR_W-1:0]            wr_ptr_gray,
  output cdc_fifo_pkg::wr_flags_t     wr_flags
);

  import cdc_fifo_pkg::*;

  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     wr_ptr_nxt;
  logic [PTR_W-1:0]     fill_nxt;
  logic [MAX_PTR_W-1:0] gray_nxt_ext;
  logic                 wr_acc;
  wr_flags_t            flags_nxt;

  // ##############################
  // Write acceptance and pointer
  // ##############################

  assign wr_acc     = wr_en && !wr_flags.full;
  assign wr_ptr_nxt = wr_ptr + PTR_W'(wr_acc);

  assign we    = wr_acc;
  assign waddr = wr_ptr[ADDR_WIDTH-1:0];

  assign gray_nxt_ext = bin_to_gray(MAX_PTR_W'(wr_ptr_nxt));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= gray_nxt_ext[PTR_W-1:0];
    end
  end

  // ##############################
  // Full and almost-full
  // ##############################

  // The synchronized read pointer lags, so the level seen here is never
  // below the true one and the flags err on the safe side.
  assign fill_nxt = wr_ptr_nxt - rd_ptr_bin_wsync;

  // Full when the addresses meet and the wrap bits differ.
  assign flags_nxt.full =
    (wr_ptr_nxt[ADDR_WIDTH-1:0] == rd_ptr_bin_wsync[ADDR_WIDTH-1:0]) &&
    (wr_ptr_nxt[ADDR_WIDTH] != rd_ptr_bin_wsync[ADDR_WIDTH]);

  assign flags_nxt.afull = int'(fill_nxt) >= FIFO_AFULL;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags <= '{full: 1'b0, afull: 1'b0};
    end else begin
      wr_flags <= flags_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gray_ptr_sync.sv
`default_nettype none

module gray_ptr_sync #(
  parameter int PTR_W = 5
) (
  input  wire              dst_clk,
  input  wire              dst_rst_n,
  input  wire  [PTR_W-1:0] gray_in,
  output logic [PTR_W-1:0] bin_out
);

  import cdc_fifo_pkg::*;

  logic [PTR_W-1:0]     sync_q1;
  logic [PTR_W-1:0]     sync_q2;
  logic [MAX_PTR_W-1:0] gray_ext;
  logic [MAX_PTR_W-1:0] bin_ext;

  // Two flops in the destination domain. Only one Gray bit changes per
  // source update, so the second stage always holds a valid pointer.
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // Back to binary so the receiving side can subtract pointers directly.
  assign gray_ext = MAX_PTR_W'(sync_q2);
  assign bin_ext  = gray_to_bin(gray_ext);
  assign bin_out  = bin_ext[PTR_W-1:0];

endmodule

`default_nettype wire

//--- rtl/fifo_dp_ram.sv
`default_nettype none

module fifo_dp_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int FIFO_DEPTH = 16,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  // Write port
  input  wire                  wr_clk,
  input  wire                  wr_rst_n,
  input  wire                  we,
  input  wire [ADDR_WIDTH-1:0] waddr,
  input  wire [DATA_WIDTH-1:0] wdata,
  // Read port
  input  wire                  rd_clk,
  input  wire                  rd_rst_n,
  input  wire                  re,
  input  wire [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic                  wr_ok;

  // No writes land in the array while the write domain is held in reset.
  assign wr_ok = we && wr_rst_n;

  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[waddr] <= wdata;
    end
  end

  // ##############################
  // Registered read port
  // ##############################

  // The output register holds its word until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/cdc_fifo_pkg.sv
`default_nettype none

package cdc_fifo_pkg;

  // ##############################
  // Pointer width limit
  // ##############################

  // Pointers are zero-extended to this width before Gray conversion.
  localparam int MAX_PTR_W = 16;

  // ##############################
  // Flag groups
  // ##############################

  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

  // ##############################
  // Gray code conversion
  // ##############################

  function automatic logic [MAX_PTR_W-1:0] bin_to_gray(input logic [MAX_PTR_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the parity of all Gray bits at and above it.
  function automatic logic [MAX_PTR_W-1:0] gray_to_bin(input logic [MAX_PTR_W-1:0] gray);
    logic [MAX_PTR_W-1:0] bin;
    bin[MAX_PTR_W-1] = gray[MAX_PTR_W-1];
    for (int i = MAX_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire
